// ==== Makefile ====
# Verilator build and run of the mem_ctrl testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_ctrl
VFLAGS    ?= --binary --assert --timing
SIMFLAGS  ?= +verilator+error+limit+100
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f verilog.f
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            fetch_x_en,
    input  mem_pkg::addr_u  pc_x,
    input  logic            fetch_y_en,
    input  mem_pkg::addr_u  pc_y,
    output logic            hit_x,
    output logic [31:0]     inst_x,
    output logic            hit_y,
    output logic [31:0]     inst_y,
    output logic            miss_valid,
    output mem_pkg::addr_u  miss_addr,
    input  logic            refill_take,
    input  logic            refill_we,
    input  mem_pkg::addr_u  refill_addr,
    input  logic [31:0]     refill_data
);

    logic [mem_pkg::num_sets-1:0] valid0, valid1;
    logic [mem_pkg::num_sets-1:0] rr;              // Next victim per set
    logic [mem_pkg::tag_w-1:0]    tag0  [mem_pkg::num_sets];
    logic [mem_pkg::tag_w-1:0]    tag1  [mem_pkg::num_sets];
    logic [31:0]                  data0 [mem_pkg::num_sets];
    logic [31:0]                  data1 [mem_pkg::num_sets];

    logic           x_pend_v, y_pend_v;
    mem_pkg::addr_u x_pend, y_pend;
    logic           fly_v;                          // Refill on the bus
    mem_pkg::addr_u fly_addr;

    logic hx0, hx1, hy0, hy1;
    logic x_cap, y_cap, fill_way1;
    logic [mem_pkg::index_w-1:0] ri;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hx0 = valid0[pc_x.fields.index] && tag0[pc_x.fields.index] == pc_x.fields.tag;
    assign hx1 = valid1[pc_x.fields.index] && tag1[pc_x.fields.index] == pc_x.fields.tag;
    assign hy0 = valid0[pc_y.fields.index] && tag0[pc_y.fields.index] == pc_y.fields.tag;
    assign hy1 = valid1[pc_y.fields.index] && tag1[pc_y.fields.index] == pc_y.fields.tag;

    // Skip addresses already pending or being fetched
    assign x_cap = fetch_x_en && !(hx0 || hx1) && !x_pend_v
                   && !(fly_v && fly_addr == pc_x) && !(y_pend_v && y_pend == pc_x);
    assign y_cap = fetch_y_en && !(hy0 || hy1) && !y_pend_v
                   && !(fly_v && fly_addr == pc_y) && !(x_pend_v && x_pend == pc_y)
                   && !(x_cap && pc_x == pc_y);

    assign miss_valid = x_pend_v || y_pend_v;
    assign miss_addr  = x_pend_v ? x_pend : y_pend;  // x slot first

    assign ri        = refill_addr.fields.index;
    assign fill_way1 = valid0[ri] && rr[ri];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_x    <= 1'b0;
            hit_y    <= 1'b0;
            valid0   <= '0;
            valid1   <= '0;
            rr       <= '0;
            x_pend_v <= 1'b0;
            y_pend_v <= 1'b0;
            fly_v    <= 1'b0;
        end else begin
            hit_x <= fetch_x_en && (hx0 || hx1);
            hit_y <= fetch_y_en && (hy0 || hy1);

            if (refill_take && x_pend_v)
                x_pend_v <= 1'b0;
            else if (x_cap)
                x_pend_v <= 1'b1;
            if (refill_take && !x_pend_v)
                y_pend_v <= 1'b0;
            else if (y_cap)
                y_pend_v <= 1'b1;

            if (refill_take)
                fly_v <= 1'b1;
            else if (refill_we)
                fly_v <= 1'b0;

            if (refill_we) begin
                if (fill_way1)
                    valid1[ri] <= 1'b1;
                else
                    valid0[ri] <= 1'b1;
                rr[ri] <= ~rr[ri];
            end
        end
    end

    always_ff @(posedge clk) begin
        inst_x <= hx0 ? data0[pc_x.fields.index] : data1[pc_x.fields.index];
        inst_y <= hy0 ? data0[pc_y.fields.index] : data1[pc_y.fields.index];
        if (x_cap)
            x_pend <= pc_x;
        if (y_cap)
            y_pend <= pc_y;
        if (refill_take)
            fly_addr <= miss_addr;
        if (refill_we && fill_way1) begin
            tag1[ri]  <= refill_addr.fields.tag;
            data1[ri] <= refill_data;
        end else if (refill_we) begin
            tag0[ri]  <= refill_addr.fields.tag;
            data0[ri] <= refill_data;
        end
    end

endmodule

// ==== hw/ls_queue.sv ====
`timescale 1ns/1ps

module ls_queue (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ls_en,
    input  logic                          ls_write,
    input  mem_pkg::addr_u                ls_addr,
    input  mem_pkg::size_t                ls_size,
    input  logic [31:0]                   ls_wdata,
    input  logic                          q_pop,
    output logic                          q_write,
    output mem_pkg::addr_u                q_addr,
    output mem_pkg::size_t                q_size,
    output logic [31:0]                   q_wdata,
    output logic                          q_empty,
    output logic [mem_pkg::count_w-1:0]   qsize
);

    localparam int ptr_w = $clog2(mem_pkg::queue_depth);

    logic                 wr_mem   [mem_pkg::queue_depth];
    mem_pkg::addr_u       addr_mem [mem_pkg::queue_depth];
    mem_pkg::size_t       size_mem [mem_pkg::queue_depth];
    logic [31:0]          data_mem [mem_pkg::queue_depth];

    logic [mem_pkg::count_w-1:0] enq_cnt;  // Total pushes, wraps
    logic [mem_pkg::count_w-1:0] deq_cnt;  // Total pops, wraps
    logic [ptr_w-1:0]            head;
    logic [ptr_w-1:0]            tail;

    // Pointers are the low bits of the running counters
    assign head = enq_cnt[ptr_w-1:0];
    assign tail = deq_cnt[ptr_w-1:0];

    assign qsize   = enq_cnt - deq_cnt;
    assign q_empty = (enq_cnt == deq_cnt);

    assign q_write = wr_mem[tail];
    assign q_addr  = addr_mem[tail];
    assign q_size  = size_mem[tail];
    assign q_wdata = data_mem[tail];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enq_cnt <= '0;
            deq_cnt <= '0;
        end else begin
            if (ls_en)
                enq_cnt <= enq_cnt + 1'b1;
            if (q_pop)
                deq_cnt <= deq_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ls_en) begin
            wr_mem[head]   <= ls_write;
            addr_mem[head] <= ls_addr;
            size_mem[head] <= ls_size;
            data_mem[head] <= ls_wdata;
        end
    end

endmodule

// ==== hw/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    // Load/store
    input  logic                         ls_en,
    input  logic                         ls_write,
    input  mem_pkg::addr_u               ls_addr,
    input  mem_pkg::size_t               ls_size,
    input  logic [31:0]                  ls_wdata,
    output logic                         ls_finish,
    output logic [31:0]                  ls_rdata,
    output logic [mem_pkg::count_w-1:0]  qsize,
    // Fetch
    input  logic                         fetch_x_en,
    input  mem_pkg::addr_u               pc_x,
    input  logic                         fetch_y_en,
    input  mem_pkg::addr_u               pc_y,
    output logic                         hit_x,
    output logic [31:0]                  inst_x,
    output logic                         hit_y,
    output logic [31:0]                  inst_y,
    // Byte-serial memory
    output logic [mem_pkg::addr_w-1:0]   mem_addr,
    output logic                         mem_wr,
    output logic [7:0]                   mem_wdata,
    input  logic [7:0]                   mem_rdata
);

    logic           q_write, q_empty, q_pop;
    mem_pkg::addr_u q_addr;
    mem_pkg::size_t q_size;
    logic [31:0]    q_wdata;

    logic           miss_valid, refill_take, refill_we;
    mem_pkg::addr_u miss_addr, refill_addr;
    logic [31:0]    refill_data;

    ls_queue u_ls_queue (
        .clk, .arst_n, .ls_en, .ls_write, .ls_addr, .ls_size, .ls_wdata, .q_pop,
        .q_write, .q_addr, .q_size, .q_wdata, .q_empty, .qsize
    );

    icache u_icache (
        .clk, .arst_n, .fetch_x_en, .pc_x, .fetch_y_en, .pc_y,
        .hit_x, .inst_x, .hit_y, .inst_y, .miss_valid, .miss_addr,
        .refill_take, .refill_we, .refill_addr, .refill_data
    );

    mem_sequencer u_mem_sequencer (
        .clk, .arst_n, .q_write, .q_addr, .q_size, .q_wdata, .q_empty, .q_pop,
        .miss_valid, .miss_addr, .refill_take, .refill_we, .refill_addr, .refill_data,
        .ls_finish, .ls_rdata, .mem_addr, .mem_wr, .mem_wdata, .mem_rdata
    );

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addr_w      = 18;                    // 256 KiB byte space
    localparam int index_w     = 6;
    localparam int tag_w       = addr_w - index_w - 2;  // 10 bits
    localparam int num_sets    = 64;

    localparam int queue_depth = 16;
    localparam int count_w     = 5;                     // Holds 0 to 16

    // Access length in bytes
    typedef logic [2:0] size_t;

    localparam size_t size_byte = 3'd1;
    localparam size_t size_half = 3'd2;
    localparam size_t size_word = 3'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
        logic [1:0]         offset;  // Byte within word
    } addr_fields_t;

    // Cache splits the address, bus and queue use it flat
    typedef union packed {
        logic [addr_w-1:0] flat;
        addr_fields_t      fields;
    } addr_u;

    // Empty slot marker, also shown by an idle bus
    localparam logic [addr_w-1:0] null_addr = '0;

endpackage

// ==== hw/mem_sequencer.sv ====
`timescale 1ns/1ps

module mem_sequencer (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         q_write,
    input  mem_pkg::addr_u               q_addr,
    input  mem_pkg::size_t               q_size,
    input  logic [31:0]                  q_wdata,
    input  logic                         q_empty,
    output logic                         q_pop,
    input  logic                         miss_valid,
    input  mem_pkg::addr_u               miss_addr,
    output logic                         refill_take,
    output logic                         refill_we,
    output mem_pkg::addr_u               refill_addr,
    output logic [31:0]                  refill_data,
    output logic                         ls_finish,
    output logic [31:0]                  ls_rdata,
    output logic [mem_pkg::addr_w-1:0]   mem_addr,
    output logic                         mem_wr,
    output logic [7:0]                   mem_wdata,
    input  logic [7:0]                   mem_rdata
);

    // Issue stage
    logic           iss_active;
    logic [2:0]     iss_cnt;      // Bytes already shown on the bus
    mem_pkg::size_t iss_size;
    logic           iss_write;
    mem_pkg::addr_u iss_base;
    logic [23:0]    iss_wsh;      // Write bytes still to go

    // Tags of the byte on the bus and of the byte arriving
    logic       bus_rd, bus_last, bus_refill;
    logic [1:0] bus_pos;
    logic       ret_rd, ret_last, ret_refill;
    logic [1:0] ret_pos;
    logic [31:0] rd_acc;
    logic [31:0] rd_word;

    logic           more, start, start_wr;
    mem_pkg::size_t next_size;

    assign more        = iss_active && iss_cnt != iss_size;
    assign q_pop       = !iss_active && !q_empty;              // Queue head wins
    assign refill_take = !iss_active && q_empty && miss_valid;
    assign start       = q_pop || refill_take;
    assign start_wr    = q_pop && q_write;
    assign next_size   = q_pop ? q_size : mem_pkg::size_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Little-endian assembly in the return stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_word = (ret_pos == 2'd0) ? 32'd0 : rd_acc;
        rd_word[{ret_pos, 3'b000} +: 8] = mem_rdata;
    end

    assign refill_we   = ret_rd && ret_last && ret_refill;
    assign refill_data = rd_word;
    assign refill_addr = iss_base;  // Held until the next start edge

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_active <= 1'b0;
            iss_cnt    <= '0;
            iss_size   <= '0;
            iss_write  <= 1'b0;
            mem_addr   <= mem_pkg::null_addr;
            mem_wr     <= 1'b0;
            bus_rd     <= 1'b0;
            bus_last   <= 1'b0;
            bus_refill <= 1'b0;
            bus_pos    <= '0;
            ret_rd     <= 1'b0;
            ret_last   <= 1'b0;
            ret_refill <= 1'b0;
            ret_pos    <= '0;
            ls_finish  <= 1'b0;
        end else begin
            if (more) begin
                iss_cnt  <= iss_cnt + 3'd1;
                mem_addr <= iss_base.flat + mem_pkg::addr_w'(iss_cnt);
                mem_wr   <= iss_write;
                bus_rd   <= !iss_write;
                bus_last <= (iss_cnt + 3'd1 == iss_size);
                bus_pos  <= iss_cnt[1:0];
            end else if (start) begin
                iss_active <= 1'b1;
                iss_cnt    <= 3'd1;
                iss_size   <= next_size;
                iss_write  <= start_wr;
                mem_addr   <= q_pop ? q_addr.flat : miss_addr.flat;
                mem_wr     <= start_wr;
                bus_rd     <= !start_wr;
                bus_last   <= (next_size == mem_pkg::size_byte);
                bus_pos    <= 2'd0;
                bus_refill <= refill_take;
            end else begin  // Idle cycle after each access
                iss_active <= 1'b0;
                mem_addr   <= mem_pkg::null_addr;
                mem_wr     <= 1'b0;
                bus_rd     <= 1'b0;
            end

            ret_rd     <= bus_rd;
            ret_last   <= bus_last;
            ret_refill <= bus_refill;
            ret_pos    <= bus_pos;
            ls_finish  <= ret_rd && ret_last && !ret_refill;
        end
    end

    always_ff @(posedge clk) begin
        if (more) begin
            mem_wdata <= iss_wsh[7:0];
            iss_wsh   <= {8'd0, iss_wsh[23:8]};
        end else if (start) begin
            iss_base  <= q_pop ? q_addr : miss_addr;
            mem_wdata <= q_wdata[7:0];
            iss_wsh   <= q_wdata[31:8];
        end
        if (ret_rd)
            rd_acc <= rd_word;
        if (ret_rd && ret_last && !ret_refill)
            ls_rdata <= rd_word;
    end

endmodule

// ==== test/mem_ctrl_chk.sv ====
`timescale 1ns/1ps

module mem_ctrl_chk (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        ls_en,
    input logic [mem_pkg::count_w-1:0] qsize,
    input logic                        mem_wr,
    input logic [mem_pkg::addr_w-1:0]  mem_addr,
    input logic                        ls_finish
);

    localparam logic [mem_pkg::count_w-1:0] full = mem_pkg::count_w'(mem_pkg::queue_depth);

    int fail_cnt = 0;

    // Core must watch qsize
    no_push_full: assert property (@(posedge clk) disable iff (!arst_n) !(ls_en && qsize == full))
        else begin
            $error("ls_en while the queue is full");
            fail_cnt++;
        end

    no_null_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_wr && mem_addr == mem_pkg::null_addr))
        else begin
            $error("memory write to the null address");
            fail_cnt++;
        end

    finish_single: assert property (@(posedge clk) disable iff (!arst_n) ls_finish |=> !ls_finish)
        else begin
            $error("ls_finish high on two cycles in a row");
            fail_cnt++;
        end

    qsize_bound: assert property (@(posedge clk) disable iff (!arst_n) qsize <= full)
        else begin
            $error("qsize above the queue depth");
            fail_cnt++;
        end

endmodule

bind mem_ctrl mem_ctrl_chk u_chk (
    .clk, .arst_n, .ls_en, .qsize, .mem_wr, .mem_addr, .ls_finish
);

// ==== test/tb_mem_ctrl.sv ====
`timescale 1ns/1ps

module tb_mem_ctrl;

    localparam int aw         = mem_pkg::addr_w;
    localparam int max_cycles = 20000;  // All six tests together need under 2000

    logic                        clk, arst_n;
    logic                        ls_en, ls_write, ls_finish, mem_wr;
    logic                        fetch_x_en, fetch_y_en, hit_x, hit_y;
    mem_pkg::addr_u              ls_addr, pc_x, pc_y;
    mem_pkg::size_t              ls_size;
    logic [31:0]                 ls_wdata, ls_rdata, inst_x, inst_y;
    logic [mem_pkg::count_w-1:0] qsize;
    logic [aw-1:0]               mem_addr;
    logic [7:0]                  mem_wdata, mem_rdata, rd_next;

    logic [7:0]     mem    [2**aw];  // Memory behind the DUT
    logic [7:0]     shadow [2**aw];  // Reference copy updated at enqueue
    logic [31:0]    exp_q [$];       // Expected load data in issue order
    logic [aw-1:0]  ix [6], iy [6];
    mem_pkg::size_t sizes [3] = '{mem_pkg::size_byte, mem_pkg::size_half, mem_pkg::size_word};
    integer         seed = 16339;
    int             cycle_cnt = 0;
    string          test_name = "reset";

    mem_ctrl u_mem_ctrl (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s: %s expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Zero-extended little-endian word from the shadow copy
    function automatic logic [31:0] ref_word(input logic [aw-1:0] a, input mem_pkg::size_t sz);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < int'(sz); k++)
            w[8*k +: 8] = shadow[a + aw'(k)];
        return w;
    endfunction

    function automatic logic [aw-1:0] rand_daddr();  // Upper half without wrap
        return aw'(18'h20000) + aw'($unsigned($random(seed)) % 32'h1FFF0);
    endfunction

    function automatic logic [aw-1:0] rand_iaddr();  // Word aligned in the lower half
        logic [aw-1:0] a;
        a = {1'b0, 15'($random(seed)), 2'b00};
        return (a == '0) ? aw'(4) : a;
    endfunction

    function automatic mem_pkg::size_t rand_size();
        int r;
        r = int'($unsigned($random(seed)) % 3);
        return sizes[r];
    endfunction

    task automatic enqueue(input logic wr, input logic [aw-1:0] a, input mem_pkg::size_t sz,
                           input logic [31:0] d);
        while (qsize == mem_pkg::count_w'(mem_pkg::queue_depth))
            tick();
        ls_en    = 1'b1;
        ls_write = wr;
        ls_addr.flat = a;
        ls_size  = sz;
        ls_wdata = d;
        if (wr) begin
            for (int k = 0; k < int'(sz); k++)
                shadow[a + aw'(k)] = d[8*k +: 8];
        end else begin
            exp_q.push_back(ref_word(a, sz));
        end
        tick();
        ls_en = 1'b0;
    endtask

    // Hold the pc until the port hits
    task automatic fetch(input logic on_y, input logic [aw-1:0] a);
        if (on_y) begin
            fetch_y_en = 1'b1;
            pc_y.flat  = a;
        end else begin
            fetch_x_en = 1'b1;
            pc_x.flat  = a;
        end
        do
            tick();
        while (!(on_y ? hit_y : hit_x));
        check_val(on_y ? "inst_y" : "inst_x", ref_word(a, mem_pkg::size_word),
                  on_y ? inst_y : inst_x);
        if (on_y)
            fetch_y_en = 1'b0;
        else
            fetch_x_en = 1'b0;
    endtask

    task automatic probe_x(input logic [aw-1:0] a, input logic exp_hit);
        fetch_x_en = 1'b1;
        pc_x.flat  = a;
        tick();
        check_val("hit_x one cycle after fetch", 32'(exp_hit), 32'(hit_x));
        if (exp_hit)
            check_val("inst_x", ref_word(a, mem_pkg::size_word), inst_x);
        fetch_x_en = 1'b0;
    endtask

    // Last request of each test is a load
    task automatic wait_drain();
        while (exp_q.size() != 0)
            tick();
    endtask

    task automatic check_memory();
        for (int i = 0; i < 2**aw; i++) begin
            assert (mem[i] === shadow[i]) else begin
                $display("ERR %s: memory byte %h expected %h, actual %h",
                         test_name, i, shadow[i], mem[i]);
                abort_run();
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, memory model, load compare, timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        rd_next = mem[mem_addr];
        if (mem_wr)
            mem[mem_addr] = mem_wdata;
        #1 mem_rdata = rd_next;  // Byte of cycle t shows in cycle t+1
    end

    always @(negedge clk) begin
        if (arst_n && ls_finish) begin
            assert (exp_q.size() > 0) else begin
                $display("ls_finish pulsed with no load outstanding");
                abort_run();
            end
            check_val("ls_rdata", exp_q.pop_front(), ls_rdata);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (u_mem_ctrl.u_chk.fail_cnt != 0) begin
            $display("A bound assertion failed before cycle %0d", cycle_cnt);
            abort_run();
        end else if (cycle_cnt >= max_cycles) begin
            $display("Run hung: no result after %0d cycles", max_cycles);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [aw-1:0] a;
        arst_n     = 1'b0;
        ls_en      = 1'b0;
        ls_write   = 1'b0;
        ls_addr    = '0;
        ls_size    = '0;
        ls_wdata   = '0;
        fetch_x_en = 1'b0;
        fetch_y_en = 1'b0;
        pc_x       = '0;
        pc_y       = '0;
        mem_rdata  = '0;
        for (int i = 0; i < 2**aw; i++) begin
            mem[i]    = 8'($random(seed));
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;

        test_name = "reset state";
        check_val("hit_x hit_y ls_finish mem_wr", 32'd0, 32'({hit_x, hit_y, ls_finish, mem_wr}));
        check_val("mem_addr", 32'd0, 32'(mem_addr));
        check_val("qsize", 32'd0, 32'(qsize));

        test_name = "fetch miss then hit";
        a = {10'h05a, 6'd3, 2'b00};
        probe_x(a, 1'b0);
        fetch(1'b0, a);
        probe_x(a, 1'b1);

        test_name = "way replacement";  // Three tags in set 21
        fork
            fetch(1'b0, {10'h011, 6'd21, 2'b00});
            fetch(1'b1, {10'h022, 6'd21, 2'b00});
        join
        fetch(1'b0, {10'h033, 6'd21, 2'b00});
        probe_x({10'h011, 6'd21, 2'b00}, 1'b0);  // Way 0 was the victim
        fetch(1'b0, {10'h011, 6'd21, 2'b00});

        test_name = "stores then loads";
        foreach (sizes[s]) begin
            a = rand_daddr();
            enqueue(1'b1, a, sizes[s], $random(seed));
            foreach (sizes[l])
                enqueue(1'b0, a, sizes[l], 32'd0);
        end
        wait_drain();
        check_memory();

        test_name = "queue occupancy";
        for (int i = 0; i < 10; i++) begin
            enqueue(!i[0], rand_daddr(), rand_size(), $random(seed));
            if (i == 0)
                check_val("qsize after first strobe", 32'd1, 32'(qsize));
            assert (int'(qsize) <= i + 1) else begin
                $display("qsize %0d exceeds the %0d requests enqueued", qsize, i + 1);
                abort_run();
            end
        end
        wait_drain();
        check_val("qsize after drain", 32'd0, 32'(qsize));

        test_name = "mixed traffic";
        foreach (ix[i]) begin
            ix[i] = rand_iaddr();
            iy[i] = rand_iaddr();
        end
        fork
            begin
                for (int i = 0; i < 24; i++)
                    enqueue(1'($random(seed)), rand_daddr(), rand_size(), $random(seed));
                enqueue(1'b0, rand_daddr(), mem_pkg::size_word, 32'd0);
            end
            foreach (ix[i])
                fetch(1'b0, ix[i]);
            foreach (iy[i])
                fetch(1'b1, iy[i]);
        join
        wait_drain();
        check_val("qsize after drain", 32'd0, 32'(qsize));
        check_memory();

        if (u_mem_ctrl.u_chk.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", u_mem_ctrl.u_chk.fail_cnt);
            abort_run();
        end
    end

endmodule

// ==== verilog.f ====
hw/mem_pkg.sv
hw/ls_queue.sv
hw/icache.sv
hw/mem_sequencer.sv
hw/mem_ctrl.sv
test/mem_ctrl_chk.sv
test/tb_mem_ctrl.sv
